// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= hssl_reg_bank_tb
DUT_TOP   ?= hssl_reg_bank_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(DUT_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/hssl_reg_bank_tb.sv
`timescale 1ns/1ps

module hssl_reg_bank_tb;

  import hssl_map_pkg::*;
  import hssl_cfg_pkg::*;

  localparam int          NUM_RT       = 8;
  localparam int          NUM_DC       = 4;
  localparam logic [15:0] VERSION      = 16'h0213;
  localparam logic [7:0]  PIPES        = 8'd6;
  localparam logic [7:0]  OUTPS        = 8'd12;
  localparam logic [1:0]  TARGET       = 2'd2;
  localparam int          RESET_CYCLES = 10;
  localparam int          MAX_CYCLES   = 600 * 20 + RESET_CYCLES;

  logic                    clk;
  logic                    resetn;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [APB_ADR_BITS-1:0] paddr;
  word_t                   pwdata;
  word_t                   prdata;
  logic                    pready;
  logic                    pslverr;
  logic                    prx_en;
  logic [PRX_ADR_BITS-1:0] prx_addr;
  word_t                   prx_wdata;
  logic [NUM_DC-1:0]       ctr_cnt;
  logic                    hs_complete;
  logic                    hs_mismatch;
  logic [SNTL_BITS-1:0]    idsi;
  logic                    hssl_stop;
  word_t                   reply_key;
  word_t                   input_wait;
  word_t                   output_wait;
  word_t                   output_tick;
  logic [OSIZE_BITS-1:0]   output_size;
  word_t                   reg_ctr      [NUM_DC-1:0];
  word_t                   reg_rt_key   [NUM_RT-1:0];
  word_t                   reg_rt_mask  [NUM_RT-1:0];
  route_t                  reg_rt_route [NUM_RT-1:0];

  // register model, index 1 of the control words is never stored
  word_t  m_ctl [7];
  word_t  m_key [NUM_RT];
  word_t  m_msk [NUM_RT];
  route_t m_rte [NUM_RT];
  word_t  m_ctr [NUM_DC];

  logic [15:0] lfsr = 16'd37;
  int          cycles = 0;

  hssl_reg_bank_top #(
    .NUM_RTREGS  (NUM_RT),
    .NUM_DCREGS  (NUM_DC),
    .HW_VERSION  (VERSION),
    .HW_NUM_PIPES(PIPES),
    .HW_NUM_OUTPS(OUTPS),
    .TARGET_FPGA (TARGET)
  ) uut (.*);

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
      $display("Test failures found");
      $fatal(1, "simulation timed out");
    end
  end

  // ---------------------------------------------------------------------------
  // random bits and model
  // ---------------------------------------------------------------------------
  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic word_t rand_bits(input int n);
    word_t r;
    logic  fb;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic void restore_defaults();
    m_ctl[0] = 32'd0;
    m_ctl[1] = 32'd0;
    m_ctl[2] = 32'hffff_fd00;
    m_ctl[3] = 32'd32;
    m_ctl[4] = 32'd0;
    m_ctl[5] = 32'd1000;
    m_ctl[6] = 32'd256;
    for (int i = 0; i < NUM_RT; i++)
    begin
      m_key[i] = 32'hffff_ffff;
      m_msk[i] = 32'd0;
      m_rte[i] = 3'd0;
    end
  endfunction

  function automatic void model_write(input logic [3:0] sec, input logic [3:0] idx,
                                      input word_t data);
    int i;
    i = int'(idx);
    case (sec)
      4'd0:
        if (i == 1)
          restore_defaults();
        else if (i < 7)
          m_ctl[i] = data;
      4'd1: if (i < NUM_RT) m_key[i] = data;
      4'd2: if (i < NUM_RT) m_msk[i] = data;
      4'd3: if (i < NUM_RT) m_rte[i] = data[2:0];
      4'd4: if (i < NUM_DC) m_ctr[i] = data;
      default: ;
    endcase
  endfunction

  function automatic word_t expect_read(input logic [3:0] sec, input logic [3:0] idx);
    int    i;
    word_t w;
    i = int'(idx);
    w = 32'hbad0_bad0;
    case (sec)
      4'd0:
        if (i == 1)
          w = 32'd0;
        else if (i < 7)
          w = m_ctl[i];
        else if (i == 14)
        begin
          w[31:20] = 12'h5ec;
          w[19:18] = TARGET;
          w[17]    = hs_mismatch;
          w[16]    = hs_complete;
          w[15:0]  = idsi;
        end
        else if (i == 15)
        begin
          w[31:24] = OUTPS;
          w[23:16] = PIPES;
          w[15:0]  = VERSION;
        end
      4'd1: if (i < NUM_RT) w = m_key[i];
      4'd2: if (i < NUM_RT) w = m_msk[i];
      4'd3: if (i < NUM_RT) w = {29'd0, m_rte[i]};
      4'd4: if (i < NUM_DC) w = m_ctr[i];
      default: ;
    endcase
    return w;
  endfunction

  // ---------------------------------------------------------------------------
  // compare tasks
  // ---------------------------------------------------------------------------
  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp)
    begin
      $display("ERR @%0t: %s got %h expected %h", $time, what, got, exp);
      $display("Test failures found");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic check_route(input route_t got, input route_t exp, input string what);
    if (got !== exp)
    begin
      $display("ERR @%0t: %s got %0d expected %0d", $time, what, got, exp);
      $display("Test failures found");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      $display("ERR @%0t: %s got %b expected %b", $time, what, got, exp);
      $display("Test failures found");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic check_outputs();
    check_bit(hssl_stop, m_ctl[0][0], "hssl_stop");
    check_word(reply_key, m_ctl[2], "reply_key");
    check_word(input_wait, m_ctl[3], "input_wait");
    check_word(output_wait, m_ctl[4], "output_wait");
    check_word(output_tick, m_ctl[5], "output_tick");
    check_word(word_t'(output_size), m_ctl[6] & 32'h3ff, "output_size");
    for (int i = 0; i < NUM_DC; i++)
      check_word(reg_ctr[i], m_ctr[i], $sformatf("reg_ctr[%0d]", i));
    for (int i = 0; i < NUM_RT; i++)
    begin
      check_word(reg_rt_key[i], m_key[i], $sformatf("reg_rt_key[%0d]", i));
      check_word(reg_rt_mask[i], m_msk[i], $sformatf("reg_rt_mask[%0d]", i));
      check_route(reg_rt_route[i], m_rte[i], $sformatf("reg_rt_route[%0d]", i));
    end
  endtask

  // ---------------------------------------------------------------------------
  // bus drivers
  // ---------------------------------------------------------------------------
  // half the packet writes hit the APB address to force a collision
  task automatic random_prx(input logic noisy, input logic [3:0] apb_sec,
                            input logic [3:0] apb_idx, output logic fired);
    logic [3:0] sec;
    logic [3:0] idx;
    word_t      data;
    fired = noisy && (rand_bits(2) == 32'd0);
    if (rand_bits(1) == 32'd1)
    begin
      sec = apb_sec;
      idx = apb_idx;
    end
    else
    begin
      sec = 4'(rand_bits(2));
      idx = 4'(rand_bits(4));
    end
    data      = rand_bits(32);
    prx_en    = fired;
    prx_addr  = {sec, idx};
    prx_wdata = data;
    if (fired)
      model_write(sec, idx, data);
  endtask

  task automatic apb_xfer(input logic wr, input logic [3:0] sec, input logic [3:0] idx,
                          input word_t data, input logic noisy, output word_t rdata);
    logic fired;
    logic done;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = {sec, idx, 2'b00};
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    done    = 1'b0;
    while (!done)
    begin
      random_prx(noisy, sec, idx, fired);
      @(negedge clk);
      // a quiet access cycle is accepted at once
      check_bit(pready, !fired, "pready after an access cycle");
      done = pready;
    end
    check_bit(pslverr, 1'b0, "pslverr at ready");
    psel    = 1'b0;
    penable = 1'b0;
    prx_en  = 1'b0;
    // the APB write lands after every packet write seen so far
    if (wr)
      model_write(sec, idx, data);
    rdata = prdata;
  endtask

  task automatic prx_write(input logic [3:0] sec, input logic [3:0] idx, input word_t data);
    @(negedge clk);
    prx_en    = 1'b1;
    prx_addr  = {sec, idx};
    prx_wdata = data;
    model_write(sec, idx, data);
    @(negedge clk);
    prx_en = 1'b0;
  endtask

  task automatic read_check(input logic [3:0] sec, input logic [3:0] idx, input logic noisy);
    word_t rd;
    apb_xfer(1'b0, sec, idx, 32'd0, noisy, rd);
    check_word(rd, expect_read(sec, idx), $sformatf("read sec %0d idx %0d", sec, idx));
  endtask

  task automatic read_sweep(input int first_sec, input int last_sec);
    for (int s = first_sec; s <= last_sec; s++)
      for (int i = 0; i < 16; i++)
        read_check(4'(s), 4'(i), 1'b0);
  endtask

  task automatic apb_write_random(input logic noisy);
    logic [3:0] sec;
    logic [3:0] idx;
    word_t      data;
    word_t      rd;
    sec  = 4'(rand_bits(2));
    idx  = 4'(rand_bits(4));
    data = rand_bits(32);
    apb_xfer(1'b1, sec, idx, data, noisy, rd);
  endtask

  // events on every line, sometimes a counter write in the same cycle
  task automatic count_events(input int n);
    word_t      ev;
    word_t      data;
    logic       hit;
    logic [3:0] idx;
    for (int k = 0; k < n; k++)
    begin
      @(negedge clk);
      ev        = rand_bits(NUM_DC);
      hit       = (rand_bits(2) == 32'd0);
      idx       = 4'(rand_bits(2));
      data      = rand_bits(32);
      ctr_cnt   = ev[NUM_DC-1:0];
      prx_en    = hit;
      prx_addr  = {4'd4, idx};
      prx_wdata = data;
      for (int i = 0; i < NUM_DC; i++)
        if (hit && int'(idx) == i)
          m_ctr[i] = data;
        else if (ev[i])
          m_ctr[i] = m_ctr[i] + 32'd1;
    end
    @(negedge clk);
    ctr_cnt = '0;
    prx_en  = 1'b0;
  endtask

  // ---------------------------------------------------------------------------
  // test sequence
  // ---------------------------------------------------------------------------
  initial
  begin
    resetn      = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    prx_en      = 1'b0;
    prx_addr    = '0;
    prx_wdata   = '0;
    ctr_cnt     = '0;
    hs_complete = 1'b0;
    hs_mismatch = 1'b0;
    idsi        = '0;
    restore_defaults();
    for (int i = 0; i < NUM_DC; i++)
      m_ctr[i] = 32'd0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;
    idsi   = 16'(rand_bits(16));

    // defaults and unmapped space
    check_outputs();
    read_sweep(0, 4);
    for (int s = 5; s < 16; s++)
      read_check(4'(s), 4'(rand_bits(4)), 1'b0);

    // plain APB traffic
    for (int n = 0; n < 60; n++)
      apb_write_random(1'b0);
    check_outputs();
    read_sweep(0, 3);

    // APB traffic with packet writes in the access cycles
    for (int n = 0; n < 60; n++)
      apb_write_random(1'b1);
    for (int n = 0; n < 30; n++)
      read_check(4'(rand_bits(3)), 4'(rand_bits(4)), 1'b1);
    check_outputs();
    read_sweep(0, 3);

    count_events(200);
    check_outputs();
    read_sweep(4, 4);

    // soft reset from APB, then from the packet port
    apb_write_random(1'b0);
    read_check(4'd0, 4'd1, 1'b0);
    prx_write(4'd0, 4'd1, rand_bits(32));
    for (int n = 0; n < 20; n++)
      prx_write(4'(rand_bits(2)), 4'(rand_bits(3)), rand_bits(32));
    begin : apb_soft_reset
      word_t rd;
      apb_xfer(1'b1, 4'd0, 4'd1, rand_bits(32), 1'b0, rd);
    end
    check_outputs();
    read_sweep(0, 4);
    for (int n = 0; n < 20; n++)
      prx_write(4'(rand_bits(2)), 4'(rand_bits(3)), rand_bits(32));
    prx_write(4'd0, 4'd1, rand_bits(32));
    check_outputs();
    read_sweep(0, 4);

    // status and version words
    for (int n = 0; n < 8; n++)
    begin
      @(negedge clk);
      hs_complete = 1'(rand_bits(1));
      hs_mismatch = 1'(rand_bits(1));
      idsi        = 16'(rand_bits(16));
      read_check(4'd0, 4'd14, 1'b0);
      read_check(4'd0, 4'd15, 1'b0);
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

// File: files.f
hdl/hssl_map_pkg.sv
hdl/hssl_cfg_pkg.sv
hdl/apb_access_fsm.sv
hdl/diag_counters.sv
hdl/control_regs.sv
hdl/route_table.sv
hdl/hssl_reg_bank_top.sv
bench/hssl_reg_bank_tb.sv

// File: hdl/apb_access_fsm.sv
`timescale 1ns/1ps

module apb_access_fsm
(
  input  logic                                    clk,
  input  logic                                    resetn,

  // APB slave
  input  logic                                    psel,
  input  logic                                    penable,
  input  logic                                    pwrite,
  input  logic [hssl_map_pkg::APB_ADR_BITS-1:0]   paddr,
  input  hssl_cfg_pkg::word_t                     pwdata,
  output hssl_cfg_pkg::word_t                     prdata,
  output logic                                    pready,
  output logic                                    pslverr,

  // packet write port
  input  logic                                    prx_en,
  input  logic [hssl_map_pkg::PRX_ADR_BITS-1:0]   prx_addr,
  input  hssl_cfg_pkg::word_t                     prx_wdata,

  // shared write bus
  output logic                                    wr_en,
  output hssl_map_pkg::sec_e                      wr_sec,
  output hssl_map_pkg::reg_idx_t                  wr_idx,
  output hssl_cfg_pkg::word_t                     wr_data,

  // read side
  output hssl_map_pkg::reg_idx_t                  rd_idx,
  input  hssl_cfg_pkg::word_t                     ctl_rdata,
  input  hssl_cfg_pkg::word_t                     key_rdata,
  input  hssl_cfg_pkg::word_t                     msk_rdata,
  input  hssl_cfg_pkg::word_t                     rte_rdata,
  input  hssl_cfg_pkg::word_t                     cnt_rdata
);

  import hssl_map_pkg::*;
  import hssl_cfg_pkg::*;

  apb_state_e state;

  sec_e     apb_sec;
  reg_idx_t apb_idx;
  sec_e     prx_sec;
  reg_idx_t prx_idx;
  logic     accept;
  word_t    rd_word;

  // ---------------------------------------------------------------------------
  // address split
  // ---------------------------------------------------------------------------
  // byte address on APB, drop the two low bits
  assign apb_idx = paddr[BYTE_BITS + REG_LSB +: REG_BITS];
  assign apb_sec = sec_e'(paddr[BYTE_BITS + SEC_LSB +: SEC_BITS]);

  assign prx_idx = prx_addr[REG_LSB +: REG_BITS];
  assign prx_sec = sec_e'(prx_addr[SEC_LSB +: SEC_BITS]);

  // access phase wins only when the packet port is quiet
  assign accept = (state == st_idle) && psel && penable && !prx_en;

  // ---------------------------------------------------------------------------
  // write bus, packet writes first
  // ---------------------------------------------------------------------------
  assign wr_en   = prx_en || (accept && pwrite);
  assign wr_sec  = prx_en ? prx_sec   : apb_sec;
  assign wr_idx  = prx_en ? prx_idx   : apb_idx;
  assign wr_data = prx_en ? prx_wdata : pwdata;

  // ---------------------------------------------------------------------------
  // read select
  // ---------------------------------------------------------------------------
  assign rd_idx = apb_idx;

  always_comb
  begin
    case (apb_sec)
      sec_ifcas: rd_word = ctl_rdata;
      sec_rtkey: rd_word = key_rdata;
      sec_rtmsk: rd_word = msk_rdata;
      sec_rtrte: rd_word = rte_rdata;
      sec_dccnt: rd_word = cnt_rdata;
      default:   rd_word = BAD_REG;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (accept && !pwrite)
      prdata <= rd_word;
  end

  // two states, done lasts a single cycle
  always_ff @(posedge clk or negedge resetn)
  begin
    if (!resetn)
      state <= st_idle;
    else
    begin
      case (state)
        st_idle: if (accept) state <= st_done;
        default: state <= st_idle;
      endcase
    end
  end

  assign pready  = (state == st_done);
  assign pslverr = 1'b0;

  // one ready pulse per transfer
  a_pready_pulse: assert property (@(posedge clk) disable iff (!resetn)
    pready |=> !pready);

  // an accepted access never shared its cycle with a packet write
  a_no_prx_at_accept: assert property (@(posedge clk) disable iff (!resetn)
    pready |-> !$past(prx_en));

endmodule

// File: hdl/control_regs.sv
`timescale 1ns/1ps

module control_regs
#(
  parameter logic [hssl_cfg_pkg::VER_BITS-1:0]   HW_VERSION   = '0,
  parameter logic [hssl_cfg_pkg::PIPES_BITS-1:0] HW_NUM_PIPES = 8'd1,
  parameter logic [hssl_cfg_pkg::OUTPS_BITS-1:0] HW_NUM_OUTPS = 8'd1,
  parameter logic [hssl_cfg_pkg::TGT_BITS-1:0]   TARGET_FPGA  = '0
)
(
  input  logic                                  clk,
  input  logic                                  resetn,
  input  logic                                  wr_en,
  input  hssl_map_pkg::sec_e                    wr_sec,
  input  hssl_map_pkg::reg_idx_t                wr_idx,
  input  hssl_cfg_pkg::word_t                   wr_data,
  input  hssl_map_pkg::reg_idx_t                rd_idx,
  input  logic                                  hs_complete,
  input  logic                                  hs_mismatch,
  input  logic [hssl_cfg_pkg::SNTL_BITS-1:0]    idsi,
  output logic                                  soft_reset,
  output hssl_cfg_pkg::word_t                   ctl_rdata,
  output logic                                  hssl_stop,
  output hssl_cfg_pkg::word_t                   reply_key,
  output hssl_cfg_pkg::word_t                   input_wait,
  output hssl_cfg_pkg::word_t                   output_wait,
  output hssl_cfg_pkg::word_t                   output_tick,
  output logic [hssl_cfg_pkg::OSIZE_BITS-1:0]   output_size
);

  import hssl_map_pkg::*;
  import hssl_cfg_pkg::*;

  word_t stop_q;
  word_t out_size_q;
  logic  ctl_wr;
  word_t status_word;
  word_t version_word;

  assign ctl_wr     = wr_en && (wr_sec == sec_ifcas);
  // soft reset register has no storage, the write itself is the pulse
  assign soft_reset = ctl_wr && (wr_idx == SOFT_RES_REG);

  // ---------------------------------------------------------------------------
  // stored control words
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk or negedge resetn)
  begin
    if (!resetn)
    begin
      stop_q      <= HSSL_STOP_DEF;
      reply_key   <= REPLY_KEY_DEF;
      input_wait  <= IN_WAIT_DEF;
      output_wait <= OUT_WAIT_DEF;
      output_tick <= OUT_TICK_DEF;
      out_size_q  <= OUT_SIZE_DEF;
    end
    else if (soft_reset)
    begin
      stop_q      <= HSSL_STOP_DEF;
      reply_key   <= REPLY_KEY_DEF;
      input_wait  <= IN_WAIT_DEF;
      output_wait <= OUT_WAIT_DEF;
      output_tick <= OUT_TICK_DEF;
      out_size_q  <= OUT_SIZE_DEF;
    end
    else if (ctl_wr)
    begin
      // indices 7 and up are dropped here
      case (wr_idx)
        HSSL_STOP_REG: stop_q      <= wr_data;
        REPLY_KEY_REG: reply_key   <= wr_data;
        IN_WAIT_REG:   input_wait  <= wr_data;
        OUT_WAIT_REG:  output_wait <= wr_data;
        OUT_TICK_REG:  output_tick <= wr_data;
        OUT_SIZE_REG:  out_size_q  <= wr_data;
        default:       ;
      endcase
    end
  end

  assign hssl_stop   = stop_q[0];
  assign output_size = out_size_q[OSIZE_BITS-1:0];

  // ---------------------------------------------------------------------------
  // read words
  // ---------------------------------------------------------------------------
  assign status_word  = {STATUS_TAG, TARGET_FPGA, hs_mismatch, hs_complete, idsi};
  assign version_word = {HW_NUM_OUTPS, HW_NUM_PIPES, HW_VERSION};

  always_comb
  begin
    case (rd_idx)
      HSSL_STOP_REG: ctl_rdata = stop_q;
      SOFT_RES_REG:  ctl_rdata = '0;
      REPLY_KEY_REG: ctl_rdata = reply_key;
      IN_WAIT_REG:   ctl_rdata = input_wait;
      OUT_WAIT_REG:  ctl_rdata = output_wait;
      OUT_TICK_REG:  ctl_rdata = output_tick;
      OUT_SIZE_REG:  ctl_rdata = out_size_q;
      STATUS_REG:    ctl_rdata = status_word;
      HW_VER_REG:    ctl_rdata = version_word;
      default:       ctl_rdata = BAD_REG;
    endcase
  end

endmodule

// File: hdl/diag_counters.sv
`timescale 1ns/1ps

module diag_counters
#(
  parameter int NUM_DCREGS = 4
)
(
  input  logic                           clk,
  input  logic                           resetn,
  input  logic [NUM_DCREGS-1:0]          ctr_cnt,
  input  logic                           wr_en,
  input  hssl_map_pkg::sec_e             wr_sec,
  input  hssl_map_pkg::reg_idx_t         wr_idx,
  input  hssl_cfg_pkg::word_t            wr_data,
  input  hssl_map_pkg::reg_idx_t         rd_idx,
  output hssl_cfg_pkg::word_t            cnt_rdata,
  output hssl_cfg_pkg::word_t            reg_ctr [NUM_DCREGS-1:0]
);

  import hssl_map_pkg::*;
  import hssl_cfg_pkg::*;

  logic sec_wr;

  assign sec_wr = wr_en && (wr_sec == sec_dccnt);

  // one counter per event line, a write overrides the count
  for (genvar i = 0; i < NUM_DCREGS; i++)
  begin : g_ctr
    always_ff @(posedge clk or negedge resetn)
    begin
      if (!resetn)
        reg_ctr[i] <= '0;
      else if (sec_wr && (wr_idx == reg_idx_t'(i)))
        reg_ctr[i] <= wr_data;
      else if (ctr_cnt[i])
        reg_ctr[i] <= reg_ctr[i] + 32'd1;
    end
  end

  always_comb
  begin
    cnt_rdata = BAD_REG;
    for (int j = 0; j < NUM_DCREGS; j++)
      if (rd_idx == reg_idx_t'(j))
        cnt_rdata = reg_ctr[j];
  end

  // indices past the last counter read as the bad-register word
  a_cnt_bad_idx: assert property (@(posedge clk) disable iff (!resetn)
    (int'(rd_idx) >= NUM_DCREGS) |-> (cnt_rdata == BAD_REG));

endmodule

// File: hdl/hssl_cfg_pkg.sv
package hssl_cfg_pkg;

  typedef logic [31:0] word_t;

  localparam int RTE_BITS = 3;
  typedef logic [RTE_BITS-1:0] route_t;

  // field widths of the status and version words
  localparam int SNTL_BITS   = 16;
  localparam int TGT_BITS    = 2;
  localparam int VER_BITS    = 16;
  localparam int PIPES_BITS  = 8;
  localparam int OUTPS_BITS  = 8;
  localparam int OSIZE_BITS  = 10;

  localparam logic [11:0] STATUS_TAG = 12'h5ec;

  // control defaults
  localparam word_t HSSL_STOP_DEF = 32'd0;
  localparam word_t REPLY_KEY_DEF = 32'hffff_fd00;
  localparam word_t IN_WAIT_DEF   = 32'd32;
  localparam word_t OUT_WAIT_DEF  = 32'd0;
  localparam word_t OUT_TICK_DEF  = 32'd1000;
  localparam word_t OUT_SIZE_DEF  = 32'd256;

  // router defaults, key of all ones never matches
  localparam word_t  RT_KEY_DEF = 32'hffff_ffff;
  localparam word_t  RT_MSK_DEF = 32'h0000_0000;
  localparam route_t RT_RTE_DEF = 3'd0;

  typedef enum logic {st_idle, st_done} apb_state_e;

endpackage

// File: hdl/hssl_map_pkg.sv
package hssl_map_pkg;

  // word address fields
  localparam int SEC_BITS = 4;
  localparam int REG_BITS = 4;
  localparam int REG_LSB  = 0;
  localparam int SEC_LSB  = REG_LSB + REG_BITS;

  // packet port uses word addresses
  localparam int PRX_ADR_BITS = SEC_BITS + REG_BITS;

  // APB addresses are byte addresses, word fields sit two bits up
  localparam int BYTE_BITS    = 2;
  localparam int APB_ADR_BITS = PRX_ADR_BITS + BYTE_BITS;

  // register sections, other codes are unmapped
  typedef enum logic [SEC_BITS-1:0] {
    sec_ifcas = 4'd0,
    sec_rtkey = 4'd1,
    sec_rtmsk = 4'd2,
    sec_rtrte = 4'd3,
    sec_dccnt = 4'd4
  } sec_e;

  typedef logic [REG_BITS-1:0] reg_idx_t;

  // interface control section
  localparam reg_idx_t HSSL_STOP_REG = 4'd0;
  localparam reg_idx_t SOFT_RES_REG  = 4'd1;
  localparam reg_idx_t REPLY_KEY_REG = 4'd2;
  localparam reg_idx_t IN_WAIT_REG   = 4'd3;
  localparam reg_idx_t OUT_WAIT_REG  = 4'd4;
  localparam reg_idx_t OUT_TICK_REG  = 4'd5;
  localparam reg_idx_t OUT_SIZE_REG  = 4'd6;
  // collected signals, not stored
  localparam reg_idx_t STATUS_REG    = 4'd14;
  localparam reg_idx_t HW_VER_REG    = 4'd15;

  localparam int NUM_IFREGS = 7;

  localparam logic [31:0] BAD_REG = 32'hbad0_bad0;

endpackage

// File: hdl/hssl_reg_bank_top.sv
`timescale 1ns/1ps

module hssl_reg_bank_top
#(
  parameter int                                  NUM_RTREGS   = 8,
  parameter int                                  NUM_DCREGS   = 4,
  parameter logic [hssl_cfg_pkg::VER_BITS-1:0]   HW_VERSION   = '0,
  parameter logic [hssl_cfg_pkg::PIPES_BITS-1:0] HW_NUM_PIPES = 8'd1,
  parameter logic [hssl_cfg_pkg::OUTPS_BITS-1:0] HW_NUM_OUTPS = 8'd1,
  parameter logic [hssl_cfg_pkg::TGT_BITS-1:0]   TARGET_FPGA  = '0
)
(
  input  logic                                  clk,
  input  logic                                  resetn,

  // APB
  input  logic                                  psel,
  input  logic                                  penable,
  input  logic                                  pwrite,
  input  logic [hssl_map_pkg::APB_ADR_BITS-1:0] paddr,
  input  hssl_cfg_pkg::word_t                   pwdata,
  output hssl_cfg_pkg::word_t                   prdata,
  output logic                                  pready,
  output logic                                  pslverr,

  // packet write port
  input  logic                                  prx_en,
  input  logic [hssl_map_pkg::PRX_ADR_BITS-1:0] prx_addr,
  input  hssl_cfg_pkg::word_t                   prx_wdata,

  // events and status
  input  logic [NUM_DCREGS-1:0]                 ctr_cnt,
  input  logic                                  hs_complete,
  input  logic                                  hs_mismatch,
  input  logic [hssl_cfg_pkg::SNTL_BITS-1:0]    idsi,

  // register outputs
  output logic                                  hssl_stop,
  output hssl_cfg_pkg::word_t                   reply_key,
  output hssl_cfg_pkg::word_t                   input_wait,
  output hssl_cfg_pkg::word_t                   output_wait,
  output hssl_cfg_pkg::word_t                   output_tick,
  output logic [hssl_cfg_pkg::OSIZE_BITS-1:0]   output_size,
  output hssl_cfg_pkg::word_t                   reg_ctr      [NUM_DCREGS-1:0],
  output hssl_cfg_pkg::word_t                   reg_rt_key   [NUM_RTREGS-1:0],
  output hssl_cfg_pkg::word_t                   reg_rt_mask  [NUM_RTREGS-1:0],
  output hssl_cfg_pkg::route_t                  reg_rt_route [NUM_RTREGS-1:0]
);

  import hssl_map_pkg::*;
  import hssl_cfg_pkg::*;

  logic     wr_en;
  sec_e     wr_sec;
  reg_idx_t wr_idx;
  word_t    wr_data;
  reg_idx_t rd_idx;
  word_t    ctl_rdata;
  word_t    key_rdata;
  word_t    msk_rdata;
  word_t    rte_rdata;
  word_t    cnt_rdata;
  logic     soft_reset;

  apb_access_fsm u_fsm (
    .clk, .resetn,
    .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
    .prx_en, .prx_addr, .prx_wdata,
    .wr_en, .wr_sec, .wr_idx, .wr_data,
    .rd_idx, .ctl_rdata, .key_rdata, .msk_rdata, .rte_rdata, .cnt_rdata
  );

  diag_counters #(.NUM_DCREGS(NUM_DCREGS)) u_ctr (
    .clk, .resetn, .ctr_cnt,
    .wr_en, .wr_sec, .wr_idx, .wr_data,
    .rd_idx, .cnt_rdata, .reg_ctr
  );

  control_regs #(
    .HW_VERSION  (HW_VERSION),
    .HW_NUM_PIPES(HW_NUM_PIPES),
    .HW_NUM_OUTPS(HW_NUM_OUTPS),
    .TARGET_FPGA (TARGET_FPGA)
  ) u_ctl (
    .clk, .resetn,
    .wr_en, .wr_sec, .wr_idx, .wr_data, .rd_idx,
    .hs_complete, .hs_mismatch, .idsi,
    .soft_reset, .ctl_rdata,
    .hssl_stop, .reply_key, .input_wait, .output_wait, .output_tick, .output_size
  );

  route_table #(.NUM_RTREGS(NUM_RTREGS)) u_rt (
    .clk, .resetn, .soft_reset,
    .wr_en, .wr_sec, .wr_idx, .wr_data, .rd_idx,
    .key_rdata, .msk_rdata, .rte_rdata,
    .reg_rt_key, .reg_rt_mask, .reg_rt_route
  );

endmodule

// File: hdl/route_table.sv
`timescale 1ns/1ps

module route_table
#(
  parameter int NUM_RTREGS = 8
)
(
  input  logic                        clk,
  input  logic                        resetn,
  input  logic                        soft_reset,
  input  logic                        wr_en,
  input  hssl_map_pkg::sec_e          wr_sec,
  input  hssl_map_pkg::reg_idx_t      wr_idx,
  input  hssl_cfg_pkg::word_t         wr_data,
  input  hssl_map_pkg::reg_idx_t      rd_idx,
  output hssl_cfg_pkg::word_t         key_rdata,
  output hssl_cfg_pkg::word_t         msk_rdata,
  output hssl_cfg_pkg::word_t         rte_rdata,
  output hssl_cfg_pkg::word_t         reg_rt_key   [NUM_RTREGS-1:0],
  output hssl_cfg_pkg::word_t         reg_rt_mask  [NUM_RTREGS-1:0],
  output hssl_cfg_pkg::route_t        reg_rt_route [NUM_RTREGS-1:0]
);

  import hssl_map_pkg::*;
  import hssl_cfg_pkg::*;

  // ---------------------------------------------------------------------------
  // entries
  // ---------------------------------------------------------------------------
  for (genvar i = 0; i < NUM_RTREGS; i++)
  begin : g_entry
    always_ff @(posedge clk or negedge resetn)
    begin
      if (!resetn)
      begin
        reg_rt_key[i]   <= RT_KEY_DEF;
        reg_rt_mask[i]  <= RT_MSK_DEF;
        reg_rt_route[i] <= RT_RTE_DEF;
      end
      else if (soft_reset)
      begin
        reg_rt_key[i]   <= RT_KEY_DEF;
        reg_rt_mask[i]  <= RT_MSK_DEF;
        reg_rt_route[i] <= RT_RTE_DEF;
      end
      else if (wr_en && (wr_idx == reg_idx_t'(i)))
      begin
        case (wr_sec)
          sec_rtkey: reg_rt_key[i]   <= wr_data;
          sec_rtmsk: reg_rt_mask[i]  <= wr_data;
          // route keeps only its low bits
          sec_rtrte: reg_rt_route[i] <= wr_data[RTE_BITS-1:0];
          default:   ;
        endcase
      end
    end
  end

  // read port, unused entries give the bad-register word
  always_comb
  begin
    key_rdata = BAD_REG;
    msk_rdata = BAD_REG;
    rte_rdata = BAD_REG;
    for (int j = 0; j < NUM_RTREGS; j++)
      if (rd_idx == reg_idx_t'(j))
      begin
        key_rdata = reg_rt_key[j];
        msk_rdata = reg_rt_mask[j];
        rte_rdata = word_t'(reg_rt_route[j]);
      end
  end

  // soft reset comes from a control write, so no router write can collide with it
  a_srst_no_rt_wr: assert property (@(posedge clk) disable iff (!resetn)
    soft_reset |-> !(wr_en && (wr_sec inside {sec_rtkey, sec_rtmsk, sec_rtrte})));

endmodule
